/* riscvPkg.sv */
// core widths, opcode and control enums, instruction union, control, hazard and pipeline structs
package riscvPkg;

  localparam int xlen = 32;                       // data and address width

  typedef logic [4:0]      regAddrT;              // register number
  typedef logic [xlen-1:0] wordT;                 // data word

  typedef enum logic [6:0] {
    opBubble = 7'b0000000,                        // reset value and flushed slots
    opLoad   = 7'b0000011,                        // lw
    opStore  = 7'b0100011,                        // sw
    opRegOp  = 7'b0110011,                        // add, sub, and, or, slt
    opImmOp  = 7'b0010011,                        // addi, andi, ori, slti
    opBranch = 7'b1100011,                        // beq
    opJal    = 7'b1101111                         // jal
  } opcodeT;

  typedef struct packed {
    logic [6:0] funct7;                           // bit 5 picks sub on R-type
    regAddrT    rs2;
    regAddrT    rs1;
    logic [2:0] funct3;
    regAddrT    rd;
    logic [6:0] opcode;
  } rFormatT;

  // same word, register fields or raw bits for the I/S/B/J immediate slices
  typedef union packed {
    rFormatT r;
    wordT    raw;
  } instrT;

  typedef enum logic [1:0] {immI, immS, immB, immJ} immSrcT;

  typedef enum logic [2:0] {
    aluAdd = 3'b000,
    aluSub = 3'b001,                              // bit 0 set means inverted b
    aluAnd = 3'b010,
    aluOr  = 3'b011,
    aluSlt = 3'b101                               // also subtracts
  } aluOpT;

  typedef enum logic [1:0] {resAlu = 2'b00, resMem = 2'b01, resPcPlus4 = 2'b10} resultSrcT;

  typedef enum logic [1:0] {fwdReg = 2'b00, fwdWb = 2'b01, fwdMem = 2'b10} forwardT;

  typedef struct packed {
    aluOpT aluOp;
    logic  aluSrc;                                // 1 selects the immediate as b
  } execCtrlT;

  typedef struct packed {
    regAddrT rs1D, rs2D;                          // sources in decode, for load-use
    regAddrT rs1E, rs2E;                          // sources in execute, for forwarding
    regAddrT rdE, rdM, rdW;
  } hazardRegsT;

  typedef struct packed {
    logic    stallF, stallD;
    logic    flushD, flushE;
    forwardT forwardA, forwardB;
  } hazardCtrlT;

  typedef struct packed {
    instrT instr;
    wordT  pc, pcPlus4;
  } fetchDecodeT;                                 // 96 bits

  typedef struct packed {
    wordT    rd1, rd2, pc;
    regAddrT rs1, rs2, rd;
    wordT    immExt, pcPlus4;
  } decodeExecT;                                  // 175 bits

  typedef struct packed {
    wordT    aluResult, writeData;
    regAddrT rd;
    wordT    pcPlus4;
  } execMemT;                                     // 101 bits

  typedef struct packed {
    wordT    aluResult, readData;
    regAddrT rd;
    wordT    pcPlus4;
  } memWbT;                                       // 101 bits

endpackage

/* alu.sv */
`timescale 1ns/1ps
// ALU with add, sub, and, or, slt and zero flag
module alu (
  input  riscvPkg::wordT  a,
  input  riscvPkg::wordT  b,
  input  riscvPkg::aluOpT op,
  output riscvPkg::wordT  result,
  output logic            zero
);
  import riscvPkg::*;

  logic subtract;                                 // sub and slt share the adder
  wordT condInvB;
  wordT sum;
  logic overflow;

  assign subtract = op[0];                        // set for aluSub and aluSlt
  assign condInvB = subtract ? ~b : b;
  assign sum      = a + condInvB + wordT'(subtract);  // two's complement via carry in

  // operands agree in sign but the sum does not
  assign overflow = ~(a[xlen-1] ^ condInvB[xlen-1]) & (a[xlen-1] ^ sum[xlen-1]);

  always_comb begin
    case (op)
      aluAdd,
      aluSub:  result = sum;
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluSlt:  result = wordT'(sum[xlen-1] ^ overflow);  // signed less-than
      default: result = '0;                       // never selected by the decoder
    endcase
  end

  assign zero = (result == '0);                   // beq equality

endmodule

/* regFile.sv */
`timescale 1ns/1ps
// 32x32 register file, two combinational reads, falling-edge write, x0 reads zero
module regFile (
  input  logic             clk,
  input  logic             writeEn,
  input  riscvPkg::regAddrT addr1,
  input  riscvPkg::regAddrT addr2,
  input  riscvPkg::regAddrT addrW,
  input  riscvPkg::wordT    dataW,
  output riscvPkg::wordT    data1,
  output riscvPkg::wordT    data2
);
  import riscvPkg::*;

  wordT mem [32];

  // falling edge so decode sees the writeback value in the same cycle
  always_ff @(negedge clk) begin
    if (writeEn) begin
      mem[addrW] <= dataW;
    end
  end

  assign data1 = (addr1 != '0) ? mem[addr1] : '0;   // x0 hardwired
  assign data2 = (addr2 != '0) ? mem[addr2] : '0;

endmodule

/* controlDecoder.sv */
`timescale 1ns/1ps
// main decoder and ALU decoder, instruction word to decode-stage control
module controlDecoder (
  input  riscvPkg::instrT     instr,
  output riscvPkg::immSrcT    immSrc,
  output riscvPkg::execCtrlT  ctrl,
  output logic                regWrite,
  output logic                memWrite,
  output logic                branch,
  output logic                jump,
  output riscvPkg::resultSrcT resultSrc
);
  import riscvPkg::*;

  logic  opValid;                                 // opcode is one of opcodeT
  logic  aluClass;                                // R/I arithmetic, funct3 picks the op
  logic  rTypeSub;                                // funct7 bit 5 means sub only on R-type
  logic  aluSrc;
  aluOpT aluOp;

  // main decoder, unknown opcodes fall out with every write enable low
  always_comb begin
    opValid   = 1'b1;
    regWrite  = 1'b0;
    memWrite  = 1'b0;
    branch    = 1'b0;
    jump      = 1'b0;
    aluSrc    = 1'b0;
    aluClass  = 1'b0;
    immSrc    = immI;
    resultSrc = resAlu;
    case (instr.r.opcode)
      opLoad: begin
        regWrite  = 1'b1;
        aluSrc    = 1'b1;                         // base + offset
        resultSrc = resMem;
      end
      opStore: begin
        memWrite = 1'b1;
        aluSrc   = 1'b1;
        immSrc   = immS;
      end
      opRegOp: begin
        regWrite = 1'b1;
        aluClass = 1'b1;
      end
      opImmOp: begin
        regWrite = 1'b1;
        aluSrc   = 1'b1;
        aluClass = 1'b1;
      end
      opBranch: begin
        branch = 1'b1;
        immSrc = immB;
      end
      opJal: begin
        regWrite  = 1'b1;
        jump      = 1'b1;
        immSrc    = immJ;
        resultSrc = resPcPlus4;                   // link value
      end
      opBubble: ;                                 // all zero after reset and flush
      default:  opValid = 1'b0;
    endcase
  end

  assign rTypeSub = (instr.r.opcode == opRegOp) && instr.r.funct7[5];

  // ALU decoder
  always_comb begin
    aluOp = aluAdd;                               // lw/sw address, jal ignores it
    if (instr.r.opcode == opBranch) begin
      aluOp = aluSub;                             // beq tests the zero flag
    end else if (aluClass) begin
      case (instr.r.funct3)
        3'b000: begin
          if (rTypeSub) aluOp = aluSub;
          else          aluOp = aluAdd;
        end
        3'b010:  aluOp = aluSlt;
        3'b110:  aluOp = aluOr;
        3'b111:  aluOp = aluAnd;
        default: aluOp = aluAdd;                  // funct3 outside the subset
      endcase
    end
  end

  assign ctrl = '{aluOp: aluOp, aluSrc: aluSrc};

  // X only before the first reset edge
  always_comb begin
    if (!$isunknown(instr.r.opcode)) begin
      assert (opValid) else $error("unimplemented opcode %b in decode", instr.r.opcode);
    end
  end

endmodule

/* controlPipeline.sv */
`timescale 1ns/1ps
// control registers for execute, memory and writeback, branch-taken logic
module controlPipeline (
  input  logic                clk,
  input  logic                reset,
  input  riscvPkg::instrT     instrD,
  input  logic                flushE,
  input  logic                zeroE,
  output riscvPkg::immSrcT    immSrcD,
  output riscvPkg::execCtrlT  execCtrlE,
  output logic                pcSrcE,
  output logic                isLoadE,
  output logic                memWriteM,
  output logic                regWriteM,
  output logic                regWriteW,
  output riscvPkg::resultSrcT resultSrcW
);
  import riscvPkg::*;

  typedef struct packed {
    logic      regWrite;
    resultSrcT resultSrc;
    logic      memWrite;
    logic      jump;
    logic      branch;
    execCtrlT  exec;
  } ctrlExT;                                      // everything execute still needs

  typedef struct packed {
    logic      regWrite;
    resultSrcT resultSrc;
    logic      memWrite;
  } ctrlMemT;

  typedef struct packed {
    logic      regWrite;
    resultSrcT resultSrc;
  } ctrlWbT;

  ctrlExT  ctrlD, ctrlE;
  ctrlMemT ctrlM;
  ctrlWbT  ctrlW;

  controlDecoder decoderD (
    .instr     (instrD),
    .immSrc    (immSrcD),
    .ctrl      (ctrlD.exec),
    .regWrite  (ctrlD.regWrite),
    .memWrite  (ctrlD.memWrite),
    .branch    (ctrlD.branch),
    .jump      (ctrlD.jump),
    .resultSrc (ctrlD.resultSrc)
  );

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ctrlE <= '0;                                // bubbles everywhere
      ctrlM <= '0;
      ctrlW <= '0;
    end else begin
      if (flushE) ctrlE <= '0;                    // squashed or stalled slot
      else        ctrlE <= ctrlD;
      ctrlM <= '{regWrite: ctrlE.regWrite, resultSrc: ctrlE.resultSrc,
                 memWrite: ctrlE.memWrite};
      ctrlW <= '{regWrite: ctrlM.regWrite, resultSrc: ctrlM.resultSrc};
    end
  end

  assign pcSrcE     = (ctrlE.branch & zeroE) | ctrlE.jump;  // taken beq or jal
  assign isLoadE    = (ctrlE.resultSrc == resMem);
  assign execCtrlE  = ctrlE.exec;
  assign memWriteM  = ctrlM.memWrite;
  assign regWriteM  = ctrlM.regWrite;
  assign regWriteW  = ctrlW.regWrite;
  assign resultSrcW = ctrlW.resultSrc;

  // a redirect squashes the slot behind it, so execute holds a bubble next cycle
  flushKillsWrites: assert property (@(posedge clk) disable iff (reset)
    pcSrcE |=> !pcSrcE && !ctrlE.regWrite && !ctrlE.memWrite)
    else $error("write enable or redirect reached execute behind a taken branch or jal");

endmodule

/* hazardUnit.sv */
`timescale 1ns/1ps
// forwarding selects, load-use stall and flush generation
module hazardUnit (
  input  logic                 clk,
  input  logic                 reset,
  input  riscvPkg::hazardRegsT regs,
  input  logic                 isLoadE,
  input  logic                 regWriteM,
  input  logic                 regWriteW,
  input  logic                 pcSrcE,
  output riscvPkg::hazardCtrlT hazard
);
  import riscvPkg::*;

  logic loadUse;                                  // lw in execute feeds decode

  // newest producer wins, x0 never forwards
  function automatic forwardT pickSource(input regAddrT src);
    if (regWriteM && (regs.rdM != '0) && (regs.rdM == src)) begin
      return fwdMem;
    end else if (regWriteW && (regs.rdW != '0) && (regs.rdW == src)) begin
      return fwdWb;
    end else begin
      return fwdReg;
    end
  endfunction

  // x0 not excluded here, a spurious stall only costs a cycle
  assign loadUse = isLoadE && ((regs.rdE == regs.rs1D) || (regs.rdE == regs.rs2D));

  always_comb begin
    hazard.forwardA = pickSource(regs.rs1E);
    hazard.forwardB = pickSource(regs.rs2E);
    hazard.stallF   = loadUse;                    // hold pc
    hazard.stallD   = loadUse;                    // hold the dependent instruction
    hazard.flushD   = pcSrcE;                     // drop the wrong-path fetch
    hazard.flushE   = loadUse || pcSrcE;          // bubble or wrong-path decode
  end

  // the bubble pushed into execute ends the stall after one cycle
  stallBubbles: assert property (@(posedge clk) disable iff (reset)
    hazard.stallD |=> !hazard.stallD)
    else $error("load-use stall did not end after one bubble");

  stallHoldsDecode: assert property (@(posedge clk) disable iff (reset)
    hazard.stallD |=> $stable(regs.rs1D) && $stable(regs.rs2D))
    else $error("decode instruction changed during a load-use stall");

endmodule

/* datapath.sv */
`timescale 1ns/1ps
// pc, four pipeline registers, immediate extension, forwarding, alu and result muxes
module datapath #(
  parameter riscvPkg::wordT ResetPc = '0
) (
  input  logic                 clk,
  input  logic                 reset,
  output riscvPkg::wordT       pcF,
  input  riscvPkg::instrT      instrF,
  output riscvPkg::instrT      instrD,
  input  riscvPkg::immSrcT     immSrcD,
  input  riscvPkg::execCtrlT   execCtrlE,
  input  logic                 pcSrcE,
  output logic                 zeroE,
  output riscvPkg::wordT       dataAdrM,
  output riscvPkg::wordT       writeDataM,
  input  riscvPkg::wordT       readDataM,
  input  logic                 regWriteW,
  input  riscvPkg::resultSrcT  resultSrcW,
  input  riscvPkg::hazardCtrlT hazard,
  output riscvPkg::hazardRegsT regs
);
  import riscvPkg::*;

  fetchDecodeT fd;
  decodeExecT  de;
  execMemT     em;
  memWbT       mw;

  wordT pcPlus4F, pcNextF;
  wordT rawD;                                     // raw view for immediate slicing
  wordT rd1D, rd2D, immExtD;
  wordT srcAE, srcBE, writeDataE, aluResultE, pcTargetE;
  wordT resultW;

  function automatic wordT pickOperand(input forwardT sel, input wordT regVal,
                                       input wordT wbVal, input wordT memVal);
    case (sel)
      fwdMem:  return memVal;                     // result one ahead
      fwdWb:   return wbVal;                      // result two ahead
      default: return regVal;
    endcase
  endfunction

  // fetch
  assign pcPlus4F = pcF + 32'd4;
  assign pcNextF  = pcSrcE ? pcTargetE : pcPlus4F;  // redirect from execute

  always_ff @(posedge clk or posedge reset) begin
    if (reset)              pcF <= ResetPc;
    else if (!hazard.stallF) pcF <= pcNextF;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fd <= '0;
    end else if (!hazard.stallD) begin
      if (hazard.flushD) fd <= '0;                // wrong-path fetch becomes a bubble
      else               fd <= '{instr: instrF, pc: pcF, pcPlus4: pcPlus4F};
    end
  end

  // decode
  assign instrD = fd.instr;
  assign rawD   = instrD.raw;

  regFile regFileD (
    .clk     (clk),
    .writeEn (regWriteW),
    .addr1   (instrD.r.rs1),
    .addr2   (instrD.r.rs2),
    .addrW   (mw.rd),
    .dataW   (resultW),
    .data1   (rd1D),
    .data2   (rd2D)
  );

  always_comb begin
    case (immSrcD)
      immI:    immExtD = {{20{rawD[31]}}, rawD[31:20]};
      immS:    immExtD = {{20{rawD[31]}}, rawD[31:25], rawD[11:7]};
      immB:    immExtD = {{20{rawD[31]}}, rawD[7], rawD[30:25], rawD[11:8], 1'b0};
      default: immExtD = {{12{rawD[31]}}, rawD[19:12], rawD[20], rawD[30:21], 1'b0};  // jal
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      de <= '0;
    end else if (hazard.flushE) begin
      de <= '0;                                   // load-use bubble or squash
    end else begin
      de <= '{rd1: rd1D, rd2: rd2D, pc: fd.pc,
              rs1: instrD.r.rs1, rs2: instrD.r.rs2, rd: instrD.r.rd,
              immExt: immExtD, pcPlus4: fd.pcPlus4};
    end
  end

  // execute
  assign srcAE      = pickOperand(hazard.forwardA, de.rd1, resultW, em.aluResult);
  assign writeDataE = pickOperand(hazard.forwardB, de.rd2, resultW, em.aluResult);
  assign srcBE      = execCtrlE.aluSrc ? de.immExt : writeDataE;
  assign pcTargetE  = de.pc + de.immExt;          // beq and jal target

  alu aluE (
    .a      (srcAE),
    .b      (srcBE),
    .op     (execCtrlE.aluOp),
    .result (aluResultE),
    .zero   (zeroE)
  );

  // memory and writeback registers
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      em <= '0;
      mw <= '0;
    end else begin
      em <= '{aluResult: aluResultE, writeData: writeDataE, rd: de.rd, pcPlus4: de.pcPlus4};
      mw <= '{aluResult: em.aluResult, readData: readDataM, rd: em.rd, pcPlus4: em.pcPlus4};
    end
  end

  assign dataAdrM   = em.aluResult;
  assign writeDataM = em.writeData;               // already forwarded in execute

  always_comb begin
    case (resultSrcW)
      resMem:     resultW = mw.readData;
      resPcPlus4: resultW = mw.pcPlus4;           // jal link
      default:    resultW = mw.aluResult;
    endcase
  end

  assign regs = '{rs1D: instrD.r.rs1, rs2D: instrD.r.rs2, rs1E: de.rs1, rs2E: de.rs2,
                  rdE: de.rd, rdM: em.rd, rdW: mw.rd};

  pcAligned: assert property (@(posedge clk) disable iff (reset) pcF[1:0] == 2'b00)
    else $error("misaligned fetch address %h", pcF);

endmodule

/* riscvCore.sv */
`timescale 1ns/1ps
// pipelined RV32I subset core, control, hazard unit and datapath
module riscvCore #(
  parameter riscvPkg::wordT ResetPc = '0          // first fetch address
) (
  input  logic            clk,
  input  logic            reset,
  output riscvPkg::wordT  pcF,
  input  riscvPkg::instrT instrF,
  output logic            memWriteM,
  output riscvPkg::wordT  dataAdrM,
  output riscvPkg::wordT  writeDataM,
  input  riscvPkg::wordT  readDataM
);
  import riscvPkg::*;

  instrT      instrD;
  immSrcT     immSrcD;
  execCtrlT   execCtrlE;
  logic       pcSrcE, zeroE, isLoadE;
  logic       regWriteM, regWriteW;
  resultSrcT  resultSrcW;
  hazardRegsT hazardRegs;                         // register numbers per stage
  hazardCtrlT hazardCtrl;                         // stalls, flushes, forward selects

  controlPipeline ctrlPipe (
    .clk(clk), .reset(reset), .instrD(instrD), .flushE(hazardCtrl.flushE),
    .zeroE(zeroE), .immSrcD(immSrcD), .execCtrlE(execCtrlE), .pcSrcE(pcSrcE),
    .isLoadE(isLoadE), .memWriteM(memWriteM), .regWriteM(regWriteM),
    .regWriteW(regWriteW), .resultSrcW(resultSrcW)
  );

  hazardUnit hazards (
    .clk(clk), .reset(reset), .regs(hazardRegs), .isLoadE(isLoadE),
    .regWriteM(regWriteM), .regWriteW(regWriteW), .pcSrcE(pcSrcE), .hazard(hazardCtrl)
  );

  datapath #(.ResetPc(ResetPc)) dp (
    .clk(clk), .reset(reset), .pcF(pcF), .instrF(instrF), .instrD(instrD),
    .immSrcD(immSrcD), .execCtrlE(execCtrlE), .pcSrcE(pcSrcE), .zeroE(zeroE),
    .dataAdrM(dataAdrM), .writeDataM(writeDataM), .readDataM(readDataM),
    .regWriteW(regWriteW), .resultSrcW(resultSrcW), .hazard(hazardCtrl),
    .regs(hazardRegs)
  );

endmodule

/* tbRiscv.sv */
`timescale 1ns/1ps
// testbench for riscvCore with program table, memory models, expected stores, checks and watchdog
module tbRiscv;
  import riscvPkg::*;

  localparam wordT ResetPc     = 32'h0;
  localparam int   ClkPeriod   = 40;
  localparam int   ResetCycles = 4;
  localparam int   ProgLen     = 30;                  // instruction words in progMem
  localparam int   NumStores   = 11;                  // entries in the store table
  localparam int   DrainCycles = 4;                   // fetch to memory stage plus one
  localparam int   TimeoutNs   = (ProgLen + 40) * ClkPeriod * 2;
  localparam int   Seed        = 32'h91aa;
  localparam int   OpLoad      = 'h03;
  localparam int   OpStore     = 'h23;
  localparam int   OpReg       = 'h33;
  localparam int   OpImm       = 'h13;

  logic  clk       = 1'b0;
  logic  reset     = 1'b1;
  instrT instrF    = '0;
  wordT  readDataM = '0;
  wordT  pcF;
  logic  memWriteM;
  wordT  dataAdrM, writeDataM;

  wordT progMem [ProgLen];
  wordT dataMem [64];                                 // 256 bytes of data memory
  wordT expAddr [NumStores];
  wordT expData [NumStores];
  int   storeCount  = 0;
  int   valueErrors = 0;
  int   seqErrors   = 0;                              // extra stores
  logic pendWrite   = 1'b0;                           // store seen at the falling edge
  wordT pendAddr, pendData;

  riscvCore #(.ResetPc(ResetPc)) i_dut (
    .clk(clk), .reset(reset), .pcF(pcF), .instrF(instrF), .memWriteM(memWriteM),
    .dataAdrM(dataAdrM), .writeDataM(writeDataM), .readDataM(readDataM)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // RV32I encodings, immediates sliced per format
  function automatic wordT rTypeWord(input int f7, input int f3, input int rd,
                                     input int rs1, input int rs2);
    return wordT'((f7 << 25) | (rs2 << 20) | (rs1 << 15) | (f3 << 12) | (rd << 7) | OpReg);
  endfunction

  function automatic wordT iTypeWord(input int op, input int f3, input int rd,
                                     input int rs1, input int imm);
    return wordT'(((imm & 'hfff) << 20) | (rs1 << 15) | (f3 << 12) | (rd << 7) | op);
  endfunction

  function automatic wordT sTypeWord(input int rs2, input int rs1, input int imm);
    return wordT'((((imm >> 5) & 'h7f) << 25) | (rs2 << 20) | (rs1 << 15) | (2 << 12) |
                  ((imm & 'h1f) << 7) | OpStore);   // sw only
  endfunction

  function automatic wordT bTypeWord(input int rs1, input int rs2, input int imm);
    return wordT'((((imm >> 12) & 1) << 31) | (((imm >> 5) & 'h3f) << 25) | (rs2 << 20) |
                  (rs1 << 15) | (((imm >> 1) & 'hf) << 8) | (((imm >> 11) & 1) << 7) |
                  'h63);                              // beq, funct3 zero
  endfunction

  function automatic wordT jTypeWord(input int rd, input int imm);
    return wordT'((((imm >> 20) & 1) << 31) | (((imm >> 1) & 'h3ff) << 21) |
                  (((imm >> 11) & 1) << 20) | (((imm >> 12) & 'hff) << 12) |
                  (rd << 7) | 'h6f);
  endfunction

  task automatic buildProgram();
    progMem[0]  = iTypeWord(OpImm, 0, 1, 0, 53);      // addi x1, x0, 53
    progMem[1]  = iTypeWord(OpImm, 0, 2, 0, -20);     // addi x2, x0, -20
    progMem[2]  = rTypeWord(0, 0, 3, 1, 2);           // add  x3, x1, x2  = 33
    progMem[3]  = rTypeWord('h20, 0, 4, 1, 3);        // sub  x4, x1, x3  = 20
    progMem[4]  = rTypeWord(0, 7, 5, 4, 2);           // and  x5, x4, x2  = 4
    progMem[5]  = rTypeWord(0, 6, 6, 5, 3);           // or   x6, x5, x3  = 0x25
    progMem[6]  = rTypeWord(0, 2, 7, 2, 6);           // slt  x7, x2, x6  = 1
    progMem[7]  = sTypeWord(7, 0, 0);                 // sw x7, 0(x0)
    progMem[8]  = sTypeWord(6, 0, 4);                 // sw x6, 4(x0)
    progMem[9]  = sTypeWord(4, 0, 8);                 // sw x4, 8(x0)
    progMem[10] = sTypeWord(5, 0, 12);                // sw x5, 12(x0)
    progMem[11] = sTypeWord(3, 0, 16);                // sw x3, 16(x0)
    progMem[12] = iTypeWord(OpLoad, 2, 8, 0, 4);      // lw  x8, 4(x0) reads 0x25 back
    progMem[13] = rTypeWord(0, 0, 9, 8, 1);           // add x9, x8, x1 = 0x5a, load-use
    progMem[14] = sTypeWord(9, 0, 20);                // sw x9, 20(x0)
    progMem[15] = bTypeWord(9, 8, 12);                // beq x9, x8 not taken
    progMem[16] = sTypeWord(1, 0, 24);                // sw x1, 24(x0)
    progMem[17] = bTypeWord(7, 7, 12);                // beq x7, x7 taken to 80
    progMem[18] = sTypeWord(2, 0, 28);                // skipped
    progMem[19] = sTypeWord(3, 0, 32);                // skipped
    progMem[20] = jTypeWord(10, 8);                   // jal x10, 88 so x10 = 84
    progMem[21] = sTypeWord(4, 0, 36);                // skipped
    progMem[22] = sTypeWord(10, 0, 40);               // sw x10, 40(x0)
    progMem[23] = rTypeWord(0, 0, 0, 1, 2);           // add x0, x1, x2 must vanish
    progMem[24] = sTypeWord(0, 0, 44);                // sw x0, 44(x0)
    progMem[25] = iTypeWord(OpImm, 7, 11, 2, 'hf0);   // andi x11, x2, 0xf0 = 0xe0
    progMem[26] = iTypeWord(OpImm, 6, 12, 11, 5);     // ori  x12, x11, 5 = 0xe5
    progMem[27] = iTypeWord(OpImm, 2, 13, 2, -19);    // slti x13, x2, -19 = 1
    progMem[28] = sTypeWord(12, 0, 48);               // sw x12, 48(x0)
    progMem[29] = sTypeWord(13, 0, 52);               // sw x13, 52(x0)
  endtask

  task automatic storeEntry(input int idx, input wordT addr, input wordT data);
    expAddr[idx] = addr;
    expData[idx] = data;
  endtask

  // stores in program order, worked out by hand
  task automatic fillExpectedStores();
    storeEntry(0, 32'h00, 32'h0000_0001);             // slt -20 < 37
    storeEntry(1, 32'h04, 32'h0000_0025);             // or
    storeEntry(2, 32'h08, 32'h0000_0014);             // sub
    storeEntry(3, 32'h0c, 32'h0000_0004);             // and
    storeEntry(4, 32'h10, 32'h0000_0021);             // add
    storeEntry(5, 32'h14, 32'h0000_005a);             // loaded word plus x1
    storeEntry(6, 32'h18, 32'h0000_0035);             // beq fall-through
    storeEntry(7, 32'h28, 32'h0000_0054);             // jal link
    storeEntry(8, 32'h2c, 32'h0000_0000);             // x0 stays zero
    storeEntry(9, 32'h30, 32'h0000_00e5);
    storeEntry(10, 32'h34, 32'h0000_0001);
  endtask

  task automatic wordCompare(input string name, input wordT got, input wordT exp);
    if (got !== exp) begin
      valueErrors++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic strobeCompare(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      valueErrors++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic recordStore();
    if (storeCount < NumStores) begin
      wordCompare("dataAdrM", dataAdrM, expAddr[storeCount]);
      wordCompare("writeDataM", writeDataM, expData[storeCount]);
    end else begin
      seqErrors++;
      $display("extra store of %h to address %h after the last expected store",
               writeDataM, dataAdrM);
    end
    storeCount++;
  endtask

  // memory models, driven mid-cycle while the core holds its outputs
  always @(negedge clk) begin
    if (pcF < wordT'(ProgLen * 4)) instrF.raw = progMem[int'(pcF >> 2)];
    else                           instrF = '0;  // bubble past the table end
    readDataM = dataMem[dataAdrM[7:2]];
    pendWrite = 1'b0;
    if (!reset && memWriteM) begin
      recordStore();
      pendWrite = 1'b1;
      pendAddr  = dataAdrM;
      pendData  = writeDataM;
    end
  end

  always @(posedge clk) begin
    if (pendWrite) dataMem[pendAddr[7:2]] = pendData;  // commit at the rising edge
  end

  initial begin
    #(TimeoutNs);
    $display("timeout after %0d ns, %0d of %0d expected stores seen",
             TimeoutNs, storeCount, NumStores);
    $display("Test failed");
    $finish;
  end

  initial begin
    void'($urandom(Seed));
    buildProgram();
    fillExpectedStores();
    foreach (dataMem[i]) begin
      dataMem[i] = $urandom;                          // words never stored stay random
    end
    repeat (ResetCycles) begin
      @(negedge clk);
      strobeCompare("memWriteM", memWriteM, 1'b0);
      wordCompare("pcF", pcF, ResetPc);
    end
    reset = 1'b0;
    @(negedge clk);
    strobeCompare("memWriteM", memWriteM, 1'b0);     // only bubbles behind the first fetch
    wordCompare("pcF", pcF, ResetPc + 32'd4);        // fetch moved on by one word
    while (storeCount < NumStores) @(negedge clk);
    repeat (DrainCycles) @(negedge clk);             // catch stray stores
    $display("run done: %0d value errors, %0d extra stores", valueErrors, seqErrors);
    if (valueErrors == 0 && seqErrors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* all.f */
riscvPkg.sv
alu.sv
regFile.sv
controlDecoder.sv
controlPipeline.sv
hazardUnit.sv
datapath.sv
riscvCore.sv
tbRiscv.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --top-module tbRiscv -f all.f -o simRiscv \
  && {
    ./obj_dir/simRiscv > sim.log 2>&1
    cat sim.log
    grep -q "Test completed successfully" sim.log
  } \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
